// File: vm16_core.f
+incdir+verification
src/vm16_isa_pkg.sv
src/vm16_core_pkg.sv
src/vm16_bram.sv
src/vm16_regfile.sv
src/vm16_decoder.sv
src/vm16_alu.sv
src/vm16_control.sv
src/vm16_core.sv
verification/vm16_clock_gen.sv
verification/vm16_checker.sv
verification/tb_vm16_core.sv

// File: run.sh
#!/bin/sh
# builds the vm16 core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f vm16_core.f --top-module tb_vm16_core \
    -Mdir "$BUILD_DIR" -o sim_vm16
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_vm16" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verification/vm16_program.svh
/* program table shared by the testbench top and the checker. Expected values are
   worked out by hand, starting from registers that hold their own index */

localparam int PROG_LEN = 28;

// instruction word, writes a register, expected register, expected value
logic [15:0] prog_word   [PROG_LEN];
logic        prog_writes [PROG_LEN];
logic [2:0]  prog_reg    [PROG_LEN];
logic [15:0] prog_value  [PROG_LEN];

// register form is opcode, rd, ra, simm5
function automatic logic [15:0] reg_word(input logic [4:0] op, input logic [2:0] rd,
                                         input logic [2:0] ra, input logic [4:0] simm5);
    return {op, rd, ra, simm5};
endfunction

function automatic logic [15:0] movi_word(input logic [2:0] rd, input logic [7:0] imm8);
    return {OP_MOVI, rd, imm8};
endfunction

task automatic set_entry(input int idx, input logic [15:0] word, input logic writes,
                         input logic [2:0] rsel, input logic [15:0] value);
    prog_word[idx]   = word;
    prog_writes[idx] = writes;
    prog_reg[idx]    = rsel;
    prog_value[idx]  = value;
endtask

task automatic fill_program();
    // r1 = r5 shows the reset contents
    set_entry(0,  reg_word(OP_MOV, 3'd1, 3'd5, 5'h00),         1'b1, 3'd1, 16'h0005);
    set_entry(1,  movi_word(3'd2, 8'ha5),                      1'b1, 3'd2, 16'h00a5);
    set_entry(2,  movi_word(3'd3, 8'h3c),                      1'b1, 3'd3, 16'h003c);
    set_entry(3,  reg_word(OP_BIT, 3'd2, 3'd3, FN_OR),         1'b1, 3'd2, 16'h00bd);
    set_entry(4,  reg_word(OP_BIT, 3'd3, 3'd2, FN_XOR),        1'b1, 3'd3, 16'h0081);
    set_entry(5,  reg_word(OP_BIT, 3'd2, 3'd3, FN_AND),        1'b1, 3'd2, 16'h0081);
    set_entry(6,  reg_word(OP_BIT, 3'd4, 3'd3, FN_NOT),        1'b1, 3'd4, 16'hff7e);
    set_entry(7,  reg_word(OP_BIT, 3'd1, 3'd6, FN_LSHFT),      1'b1, 3'd1, 16'h0140);
    set_entry(8,  reg_word(OP_BIT, 3'd4, 3'd7, FN_RSHFT),      1'b1, 3'd4, 16'h01fe);
    // unsigned group, 6 - 7 wraps and so does the add of 19 after it
    set_entry(9,  reg_word(OP_ARITH_U, 3'd5, 3'd4, FN_ADD),    1'b1, 3'd5, 16'h0203);
    set_entry(10, reg_word(OP_ARITH_U, 3'd6, 3'd7, FN_SUB),    1'b1, 3'd6, 16'hffff);
    set_entry(11, reg_word(OP_ARITH_U, 3'd6, 3'd0, 5'h13),     1'b1, 3'd6, 16'h0012);
    // signed group on negative operands, simm5 of 5'h1f is -1
    set_entry(12, reg_word(OP_BIT, 3'd7, 3'd2, FN_NOT),        1'b1, 3'd7, 16'hff7e);
    set_entry(13, reg_word(OP_ARITH_S, 3'd7, 3'd6, FN_ADD),    1'b1, 3'd7, 16'hff90);
    set_entry(14, reg_word(OP_ARITH_S, 3'd0, 3'd7, FN_SUB),    1'b1, 3'd0, 16'h0070);
    set_entry(15, reg_word(OP_ARITH_S, 3'd7, 3'd0, FN_SUB),    1'b1, 3'd7, 16'hff20);
    set_entry(16, reg_word(OP_ARITH_S, 3'd7, 3'd0, 5'h1f),     1'b1, 3'd7, 16'hff21);
    set_entry(17, movi_word(3'd3, 8'h80),                      1'b1, 3'd3, 16'h0080);
    set_entry(18, movi_word(3'd2, 8'h08),                      1'b1, 3'd2, 16'h0008);
    set_entry(19, reg_word(OP_BIT, 3'd3, 3'd2, FN_LSHFT),      1'b1, 3'd3, 16'h8000);
    // two negatives that overflow to a positive
    set_entry(20, reg_word(OP_ARITH_S, 3'd3, 3'd7, FN_ADD),    1'b1, 3'd3, 16'h7f21);
    // store r5 to 0x12 + 3, load it back through 8 + 13
    set_entry(21, reg_word(OP_SW, 3'd5, 3'd6, 5'h03),          1'b0, 3'd0, 16'h0000);
    set_entry(22, reg_word(OP_LW, 3'd1, 3'd2, 5'h0d),          1'b1, 3'd1, 16'h0203);
    // unknown opcode, unknown BIT function, NOP, then HALT
    set_entry(23, reg_word(5'h0a, 3'd4, 3'd4, 5'h00),          1'b0, 3'd0, 16'h0000);
    set_entry(24, reg_word(OP_BIT, 3'd4, 3'd4, 5'h08),         1'b0, 3'd0, 16'h0000);
    set_entry(25, reg_word(OP_NOP, 3'd0, 3'd0, 5'h00),         1'b0, 3'd0, 16'h0000);
    set_entry(26, reg_word(OP_HALT, 3'd0, 3'd0, 5'h00),        1'b0, 3'd0, 16'h0000);
    // never reached
    set_entry(27, movi_word(3'd0, 8'h55),                      1'b0, 3'd0, 16'h0000);
endtask

// File: verification/tb_vm16_core.sv
/* testbench top. The program is written into the instruction RAM while reset is held,
   then the core runs until halted, with a timeout on every wait */
`timescale 1ns/10ps
module tb_vm16_core;
    import vm16_isa_pkg::*;

    localparam int RESET_TIMEOUT = 100;
    localparam int HALT_TIMEOUT  = 2000;
    localparam int DRAIN_CYCLES  = 20;

    logic        clk;
    logic        reset;
    logic        hold_reset;
    logic        prog_we;
    logic [15:0] prog_addr;
    logic [15:0] prog_data;
    logic        wb_valid;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    logic        halted;
    int          checked_count;
    int          mismatch_count;
    int          extra_count;
    int          missing_count;
    int          timeout_count;

    `include "vm16_program.svh"

    vm16_clock_gen u_clock_gen (
        .hold  (hold_reset),
        .clk   (clk),
        .reset (reset)
    );

    vm16_core #(
        .INSTR_DEPTH   (64),
        .SCRATCH_DEPTH (64)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    vm16_checker u_checker (
        .clk            (clk),
        .reset          (reset),
        .wb_valid       (wb_valid),
        .wb_reg         (wb_reg),
        .wb_data        (wb_data),
        .halted         (halted),
        .checked_count  (checked_count),
        .mismatch_count (mismatch_count),
        .extra_count    (extra_count),
        .missing_count  (missing_count)
    );

    // one word per cycle, then let reset run out
    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 16'(i);
            prog_data <= prog_word[i];
        end
        @(posedge clk);
        prog_we    <= 1'b0;
        prog_addr  <= '0;
        prog_data  <= '0;
        hold_reset <= 1'b0;
    endtask

    initial begin
        int cycles;
        int errors;
        $timeformat(-9, 0, " ns", 0);
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_data     = '0;
        hold_reset    = 1'b1;
        timeout_count = 0;
        fill_program();
        load_program();

        cycles = 0;
        while (reset && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) begin
            $display("timeout: reset still high %0d cycles after the program load",
                     RESET_TIMEOUT);
            timeout_count++;
        end else begin
            cycles = 0;
            while (!halted && cycles < HALT_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!halted) begin
                $display("timeout: core did not halt within %0d cycles", HALT_TIMEOUT);
                timeout_count++;
            end else begin
                // keep the checker watching for write-backs after HALT
                for (int i = 0; i < DRAIN_CYCLES; i++) begin
                    @(negedge clk);
                end
            end
        end

        errors = mismatch_count + extra_count + missing_count + timeout_count;
        $display("write-backs checked %0d, mismatches %0d, extra %0d, missing %0d, timeouts %0d",
                 checked_count, mismatch_count, extra_count, missing_count, timeout_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/vm16_checker.sv
/* compares each write-back on the trace with the next writing entry of the program
   table. Also catches write-backs past the end and ones missing at halt */
`timescale 1ns/10ps
module vm16_checker (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_valid,
    input  logic [2:0]  wb_reg,
    input  logic [15:0] wb_data,
    input  logic        halted,
    output int          checked_count,
    output int          mismatch_count,
    output int          extra_count,
    output int          missing_count
);
    import vm16_isa_pkg::*;

    `include "vm16_program.svh"

    // table indices of the entries that write a register, in program order
    int   write_entry [$];
    int   checked_q  = 0;
    int   mismatch_q = 0;
    int   extra_q    = 0;
    int   missing_q  = 0;
    logic halt_seen  = 1'b0;

    initial begin
        fill_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            if (prog_writes[i]) begin
                write_entry.push_back(i);
            end
        end
    end

    // trace and halted come from registers, so the values before the edge are settled
    always @(posedge clk) begin
        int idx;
        if (!reset) begin
            if (wb_valid) begin
                if (halted || checked_q >= write_entry.size()) begin
                    $display("extra write-back at %0t: r%0d = %h after the last expected one",
                             $time, wb_reg, wb_data);
                    extra_q <= extra_q + 1;
                end else begin
                    idx = write_entry[checked_q];
                    if (wb_reg !== prog_reg[idx] || wb_data !== prog_value[idx]) begin
                        $display("FAILED %0t: entry %0d wrote r%0d = %h, expected r%0d = %h",
                                 $time, idx, wb_reg, wb_data, prog_reg[idx], prog_value[idx]);
                        mismatch_q <= mismatch_q + 1;
                    end
                    checked_q <= checked_q + 1;
                end
            end
            if (halted && !halt_seen) begin
                halt_seen <= 1'b1;
                if (checked_q < write_entry.size()) begin
                    $display("core halted with write-backs missing: expected %0d, saw %0d",
                             write_entry.size(), checked_q);
                    missing_q <= write_entry.size() - checked_q;
                end
            end
        end
    end

    assign checked_count  = checked_q;
    assign mismatch_count = mismatch_q;
    assign extra_count    = extra_q;
    assign missing_count  = missing_q;

endmodule

// File: verification/vm16_clock_gen.sv
/* 10 ns clock. reset is high from time 0 while hold is high, and for
   RESET_CYCLES more rising edges after hold drops */
`timescale 1ns/10ps
module vm16_clock_gen #(
    parameter int RESET_CYCLES = 3
) (
    input  logic hold,
    output logic clk,
    output logic reset
);

    logic clk_q         = 1'b0;
    logic reset_q       = 1'b1;
    int   release_count = 0;

    initial begin
        forever begin
            #5 clk_q = ~clk_q;
        end
    end

    always @(posedge clk_q) begin
        if (hold) begin
            release_count <= 0;
            reset_q       <= 1'b1;
        end else if (release_count < RESET_CYCLES) begin
            release_count <= release_count + 1;
            reset_q       <= 1'b1;
        end else begin
            reset_q <= 1'b0;
        end
    end

    assign clk   = clk_q;
    assign reset = reset_q;

endmodule

// File: src/vm16_core.sv
/* core top. prog_we may only be used while reset is held. The wb_* trace is the
   register file write port, one wb_valid pulse per register write */
`timescale 1ns/10ps
module vm16_core #(
    parameter int INSTR_DEPTH   = 64,
    parameter int SCRATCH_DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     prog_we,
    input  vm16_core_pkg::word_t     prog_addr,
    input  vm16_core_pkg::word_t     prog_data,
    output logic                     wb_valid,
    output vm16_core_pkg::reg_sel_t  wb_reg,
    output vm16_core_pkg::word_t     wb_data,
    output logic                     halted
);
    import vm16_isa_pkg::*;
    import vm16_core_pkg::*;

    word_t    pc;
    word_t    instr_addr;
    word_t    instr_rdata;
    instr_t   instr;
    reg_sel_t rd;
    reg_sel_t ra;
    logic [7:0] imm8;
    logic [4:0] simm5;
    alu_op_t  alu_op;
    logic     has_imm8;
    logic     has_we;
    logic     has_mem;
    logic     has_mem_we;
    logic     halt;
    reg_sel_t reg_rsel;
    word_t    reg_rdata;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    word_t    mem_addr;
    word_t    mem_wdata;
    logic     mem_we;
    word_t    mem_rdata;

    // program loader owns the instruction RAM port while it writes
    assign instr_addr = prog_we ? prog_addr : pc;

    vm16_bram #(.DEPTH(INSTR_DEPTH)) u_instr_mem (
        .clk   (clk),
        .addr  (instr_addr),
        .wdata (prog_data),
        .we    (prog_we),
        .rdata (instr_rdata)
    );

    vm16_bram #(.DEPTH(SCRATCH_DEPTH)) u_scratch_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

    vm16_control u_control (
        .clk         (clk),
        .reset       (reset),
        .instr_rdata (instr_rdata),
        .pc          (pc),
        .instr       (instr),
        .rd          (rd),
        .ra          (ra),
        .imm8        (imm8),
        .simm5       (simm5),
        .has_imm8    (has_imm8),
        .has_we      (has_we),
        .has_mem     (has_mem),
        .has_mem_we  (has_mem_we),
        .halt        (halt),
        .reg_rsel    (reg_rsel),
        .reg_rdata   (reg_rdata),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_result  (alu_result),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_we      (mem_we),
        .mem_rdata   (mem_rdata),
        .reg_we      (wb_valid),
        .reg_wsel    (wb_reg),
        .reg_wdata   (wb_data),
        .halted      (halted)
    );

    vm16_decoder u_decoder (
        .instr      (instr),
        .rd         (rd),
        .ra         (ra),
        .imm8       (imm8),
        .simm5      (simm5),
        .alu_op     (alu_op),
        .has_imm8   (has_imm8),
        .has_we     (has_we),
        .has_mem    (has_mem),
        .has_mem_we (has_mem_we),
        .halt       (halt)
    );

    vm16_alu u_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .simm5  (simm5),
        .result (alu_result)
    );

    vm16_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .rsel  (reg_rsel),
        .rdata (reg_rdata),
        .we    (wb_valid),
        .wsel  (wb_reg),
        .wdata (wb_data)
    );

endmodule

// File: src/vm16_control.sv
/* multi-cycle sequencer. Register ops take 3 cycles and LW/SW take 5, with no stalls.
   The instruction RAM must give read data one cycle after the pc */
`timescale 1ns/10ps
module vm16_control (
    input  logic                     clk,
    input  logic                     reset,
    input  vm16_core_pkg::word_t     instr_rdata,
    output vm16_core_pkg::word_t     pc,
    output vm16_isa_pkg::instr_t     instr,
    input  vm16_core_pkg::reg_sel_t  rd,
    input  vm16_core_pkg::reg_sel_t  ra,
    input  logic [7:0]               imm8,
    input  logic [4:0]               simm5,
    input  logic                     has_imm8,
    input  logic                     has_we,
    input  logic                     has_mem,
    input  logic                     has_mem_we,
    input  logic                     halt,
    output vm16_core_pkg::reg_sel_t  reg_rsel,
    input  vm16_core_pkg::word_t     reg_rdata,
    output vm16_core_pkg::word_t     alu_a,
    output vm16_core_pkg::word_t     alu_b,
    input  vm16_core_pkg::word_t     alu_result,
    output vm16_core_pkg::word_t     mem_addr,
    output vm16_core_pkg::word_t     mem_wdata,
    output logic                     mem_we,
    input  vm16_core_pkg::word_t     mem_rdata,
    output logic                     reg_we,
    output vm16_core_pkg::reg_sel_t  reg_wsel,
    output vm16_core_pkg::word_t     reg_wdata,
    output logic                     halted
);
    import vm16_core_pkg::*;

    core_state_t state;
    word_t       op_a;
    word_t       op_b;
    word_t       operand_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_START;
            pc    <= '0;
            instr <= '0;
        end else begin
            case (state)
                // RAM is reading address 0 this cycle
                ST_START: state <= ST_FETCH;
                ST_FETCH: begin
                    instr <= instr_rdata;
                    pc    <= pc + word_t'(1);
                    state <= ST_READ_RD;
                end
                ST_READ_RD: state <= ST_READ_RA;
                ST_READ_RA: begin
                    if (halt) begin
                        state <= ST_HALT;
                    end else if (has_mem) begin
                        state <= ST_MEM;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                ST_MEM:  state <= ST_WB;
                ST_WB:   state <= ST_FETCH;
                default: state <= ST_HALT;
            endcase
        end
    end

    // operand b is the imm8 for MOVI, otherwise the ra register
    assign operand_b = has_imm8 ? {{(WORD_WIDTH-8){1'b0}}, imm8} : reg_rdata;

    always_ff @(posedge clk) begin
        if (state == ST_READ_RD) begin
            op_a <= reg_rdata;
        end
        if (state == ST_READ_RA) begin
            op_b <= operand_b;
        end
    end

    assign reg_rsel = (state == ST_READ_RA) ? ra : rd;
    assign alu_a    = op_a;
    assign alu_b    = (state == ST_READ_RA) ? operand_b : op_b;

    // in MEM and WB the ALU passes the latched base through
    assign mem_addr  = alu_result + {{(WORD_WIDTH-5){1'b0}}, simm5};
    assign mem_wdata = op_a;
    assign mem_we    = has_mem_we && (state == ST_MEM);

    assign reg_we    = has_we && (has_mem ? (state == ST_WB) : (state == ST_READ_RA));
    assign reg_wsel  = rd;
    assign reg_wdata = (state == ST_WB) ? mem_rdata : alu_result;

    assign halted = (state == ST_HALT);

endmodule

// File: src/vm16_alu.sv
/* combinational ALU. a is the rd value, b the ra value or the MOVI immediate */
`timescale 1ns/10ps
module vm16_alu (
    input  vm16_isa_pkg::alu_op_t  op,
    input  vm16_core_pkg::word_t   a,
    input  vm16_core_pkg::word_t   b,
    input  logic [4:0]             simm5,
    output vm16_core_pkg::word_t   result
);
    import vm16_isa_pkg::*;
    import vm16_core_pkg::*;

    word_t imm_zext;
    word_t imm_sext;

    assign imm_zext = {{(WORD_WIDTH-5){1'b0}}, simm5};
    assign imm_sext = {{(WORD_WIDTH-5){simm5[4]}}, simm5};

    always_comb begin
        case (op)
            // NOT inverts b, not a
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_AND:   result = a & b;
            ALU_NOT:   result = ~b;
            ALU_LSHFT: result = a << b;
            ALU_RSHFT: result = a >> b;
            // moves pass b, loads and stores pass b as the base address
            ALU_MOV, ALU_MOVI, ALU_LW, ALU_SW: result = b;
            ALU_UADD:  result = a + b;
            ALU_USUB:  result = a - b;
            ALU_UADDI: result = a + imm_zext;
            // two's complement, so these wrap exactly like the unsigned ops
            ALU_SADD:  result = word_t'($signed(a) + $signed(b));
            ALU_SSUB:  result = word_t'($signed(a) - $signed(b));
            ALU_SSUBI: result = word_t'($signed(a) - $signed(imm_sext));
            default:   result = '0;
        endcase
    end

endmodule

// File: src/vm16_decoder.sv
/* combinational decode of the instruction register. Unknown opcodes and function
   codes come out as ALU_NOP with every flag low */
`timescale 1ns/10ps
module vm16_decoder (
    input  vm16_isa_pkg::instr_t     instr,
    output vm16_core_pkg::reg_sel_t  rd,
    output vm16_core_pkg::reg_sel_t  ra,
    output logic [7:0]               imm8,
    output logic [4:0]               simm5,
    output vm16_isa_pkg::alu_op_t    alu_op,
    output logic                     has_imm8,
    output logic                     has_we,
    output logic                     has_mem,
    output logic                     has_mem_we,
    output logic                     halt
);
    import vm16_isa_pkg::*;

    logic imm_form;

    // both views of the same word
    assign rd    = instr.r.rd;
    assign ra    = instr.r.ra;
    assign simm5 = instr.r.simm5;
    assign imm8  = instr.i.imm8;

    // ARITH immediate ops are flagged by bit 4 of the function code
    assign imm_form = |(instr.r.simm5 & FN_ADDI);

    always_comb begin
        alu_op = ALU_NOP;
        case (instr.r.opcode)
            OP_LW:   alu_op = ALU_LW;
            OP_SW:   alu_op = ALU_SW;
            OP_MOV:  alu_op = ALU_MOV;
            OP_MOVI: alu_op = ALU_MOVI;
            OP_BIT: begin
                case (func_t'(instr.r.simm5))
                    FN_OR:    alu_op = ALU_OR;
                    FN_XOR:   alu_op = ALU_XOR;
                    FN_AND:   alu_op = ALU_AND;
                    FN_NOT:   alu_op = ALU_NOT;
                    FN_LSHFT: alu_op = ALU_LSHFT;
                    FN_RSHFT: alu_op = ALU_RSHFT;
                    default:  alu_op = ALU_NOP;
                endcase
            end
            OP_ARITH_U: begin
                if (imm_form) begin
                    alu_op = ALU_UADDI;
                end else if (func_t'(instr.r.simm5) == FN_ADD) begin
                    alu_op = ALU_UADD;
                end else if (func_t'(instr.r.simm5) == FN_SUB) begin
                    alu_op = ALU_USUB;
                end
            end
            OP_ARITH_S: begin
                if (imm_form) begin
                    alu_op = ALU_SSUBI;
                end else if (func_t'(instr.r.simm5) == FN_ADD) begin
                    alu_op = ALU_SADD;
                end else if (func_t'(instr.r.simm5) == FN_SUB) begin
                    alu_op = ALU_SSUB;
                end
            end
            default: alu_op = ALU_NOP;
        endcase
    end

    // SW is the only valid op that leaves the registers alone
    assign has_we     = (alu_op != ALU_NOP) && (alu_op != ALU_SW);
    assign has_imm8   = (instr.r.opcode == OP_MOVI);
    assign has_mem    = (instr.r.opcode == OP_LW) || (instr.r.opcode == OP_SW);
    assign has_mem_we = (instr.r.opcode == OP_SW);
    assign halt       = (instr.r.opcode == OP_HALT);

endmodule

// File: src/vm16_regfile.sv
/* eight general registers, each reset to its own index. One asynchronous read port
   and one clocked write port */
`timescale 1ns/10ps
module vm16_regfile (
    input  logic                     clk,
    input  logic                     reset,
    input  vm16_core_pkg::reg_sel_t  rsel,
    output vm16_core_pkg::word_t     rdata,
    input  logic                     we,
    input  vm16_core_pkg::reg_sel_t  wsel,
    input  vm16_core_pkg::word_t     wdata
);
    import vm16_core_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            // r0 = 0, r1 = 1 ... r7 = 7
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= word_t'(i);
            end
        end else if (we) begin
            regs[wsel] <= wdata;
        end
    end

    assign rdata = regs[rsel];

endmodule

// File: src/vm16_bram.sv
/* single-port RAM, read data valid one cycle after the address. Address bits above
   the depth are dropped, and a write cycle keeps the old read data */
`timescale 1ns/10ps
module vm16_bram #(
    parameter int DEPTH = 64
) (
    input  logic                  clk,
    input  vm16_core_pkg::word_t  addr,
    input  vm16_core_pkg::word_t  wdata,
    input  logic                  we,
    output vm16_core_pkg::word_t  rdata
);
    import vm16_core_pkg::*;

    localparam int ADDR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    word_t mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr[ADDR_BITS-1:0]] <= wdata;
        end else begin
            rdata <= mem[addr[ADDR_BITS-1:0]];
        end
    end

endmodule

// File: src/vm16_core_pkg.sv
/* data path widths and control states of the core */
package vm16_core_pkg;

    localparam int WORD_WIDTH = 16;
    localparam int REG_COUNT  = 8;

    typedef logic [WORD_WIDTH-1:0]         word_t;
    typedef logic [$clog2(REG_COUNT)-1:0]  reg_sel_t;

    // one instruction walks FETCH, READ_RD, READ_RA and, for memory ops, MEM and WB
    typedef enum logic [2:0] {
        ST_START,
        ST_FETCH,
        ST_READ_RD,
        ST_READ_RA,
        ST_MEM,
        ST_WB,
        ST_HALT
    } core_state_t;

endpackage

// File: src/vm16_isa_pkg.sv
/* instruction set encodings for the 16-bit core. UADDI and SSUBI are any ARITH function
   code with bit 4 set, and the whole simm5 field is then the immediate */
package vm16_isa_pkg;

    // top five bits of every instruction word
    typedef enum logic [4:0] {
        OP_NOP     = 5'h00,
        OP_LW      = 5'h01,
        OP_SW      = 5'h02,
        OP_BIT     = 5'h03,
        OP_MOV     = 5'h04,
        OP_MOVI    = 5'h05,
        OP_ARITH_U = 5'h06,
        OP_ARITH_S = 5'h07,
        OP_HALT    = 5'h1f
    } opcode_t;

    // simm5 read as a function code, the group opcode picks signed or unsigned
    typedef enum logic [4:0] {
        FN_OR    = 5'h00,
        FN_XOR   = 5'h01,
        FN_AND   = 5'h02,
        FN_NOT   = 5'h03,
        FN_LSHFT = 5'h04,
        FN_RSHFT = 5'h05,
        FN_ADD   = 5'h06,
        FN_SUB   = 5'h07,
        FN_ADDI  = 5'h10
    } func_t;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_MOV, ALU_MOVI, ALU_LW, ALU_SW,
        ALU_OR, ALU_XOR, ALU_AND, ALU_NOT, ALU_LSHFT, ALU_RSHFT,
        ALU_UADD, ALU_USUB, ALU_UADDI,
        ALU_SADD, ALU_SSUB, ALU_SSUBI
    } alu_op_t;

    // MOVI form
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rd;
        logic [7:0] imm8;
    } instr_imm_t;

    // register form, also used by LW/SW and the BIT/ARITH groups
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rd;
        logic [2:0] ra;
        logic [4:0] simm5;
    } instr_reg_t;

    typedef union packed {
        instr_imm_t i;
        instr_reg_t r;
    } instr_t;

endpackage
